/* cnode_proc.f */
+incdir+hw
hw/cnode_pkg.sv
hw/cnode_sorter.sv
hw/cnode_row_fifo.sv
hw/cnode_flush.sv
hw/cnode_proc.sv
test/cnode_proc_props.sv
test/cnode_proc_tb.sv

/* hw/cnode_flush.sv */
// ---------------------------------------
// flush engine, record back to CN_DEG messages
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cnode_macros.svh"

module cnode_flush (
  input  logic                 iclk,
  input  logic                 ireset,
  // record from the FIFO
  input  logic                 pop_valid,
  output logic                 pop_ready,
  input  cnode_pkg::mag_t      pop_min1,
  input  cnode_pkg::mag_t      pop_min2,
  input  cnode_pkg::idx_t      pop_min1_idx,
  input  cnode_pkg::sign_vec_t pop_signs,
  input  logic                 pop_parity,
  // output stream
  output logic                 out_valid,
  input  logic                 out_ready,
  output cnode_pkg::llr_t      out_llr,
  output logic                 out_last,
  output logic                 out_parity_fail
);

  import cnode_pkg::*;

  flush_state_t state;
  idx_t         edge_cnt;   // edge held in the output register
  logic         take, out_fire;

  // held record, minima already normalized
  mag_t         st_min1, st_min2;
  idx_t         st_idx;
  sign_vec_t    st_signs;
  logic         st_parity;

  // source of the next message
  mag_t         src_min1, src_min2;
  idx_t         src_idx, src_edge;
  sign_vec_t    src_signs;
  logic         src_parity;
  mag_t         msg_mag;
  logic         msg_sign;
  llr_t         msg_llr;

  // m * NORM / 8 rounded, 3 extra bits for the product
  function automatic mag_t normalize(input mag_t m);
    logic [`CNODE_LLR_W+1:0] tmp;
    tmp = (`CNODE_LLR_W+2)'(m) * (`CNODE_LLR_W+2)'(`CNODE_NORM) + (`CNODE_LLR_W+2)'(4);
    return tmp[`CNODE_LLR_W+1:3];
  endfunction

  assign pop_ready = (state == FL_IDLE);
  assign take      = pop_valid & pop_ready;
  assign out_fire  = out_valid & out_ready;

  //---------------------------------------
  // message build
  //---------------------------------------

  always_comb begin
    if (state == FL_IDLE) begin  // edge 0 straight off the FIFO
      src_min1   = normalize(pop_min1);
      src_min2   = normalize(pop_min2);
      src_idx    = pop_min1_idx;
      src_signs  = pop_signs;
      src_parity = pop_parity;
      src_edge   = '0;
    end else begin
      src_min1   = st_min1;
      src_min2   = st_min2;
      src_idx    = st_idx;
      src_signs  = st_signs;
      src_parity = st_parity;
      src_edge   = edge_cnt + 1'b1;
    end
    msg_mag  = (src_edge == src_idx) ? src_min2 : src_min1;  // min over the others
    msg_sign = src_signs[src_edge] ^ src_parity;             // product of the others
    msg_llr  = ({1'b0, msg_mag} ^ {`CNODE_LLR_W{msg_sign}}) + msg_sign;
  end

  //---------------------------------------
  // FSM and output register
  //---------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= FL_IDLE;
      edge_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      case (state)
        FL_IDLE: if (take) begin
          state     <= FL_EMIT;
          edge_cnt  <= '0;
          out_valid <= 1'b1;
        end
        FL_EMIT: if (out_fire) begin
          if (out_last) begin      // row done, idle for one cycle
            state     <= FL_IDLE;
            out_valid <= 1'b0;
          end else begin
            edge_cnt  <= edge_cnt + 1'b1;
          end
        end
        default: state <= FL_IDLE;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (take) begin  // normalize once per row
      st_min1   <= src_min1;
      st_min2   <= src_min2;
      st_idx    <= pop_min1_idx;
      st_signs  <= pop_signs;
      st_parity <= pop_parity;
    end
    // load on take or on each accepted beat but the last
    if (take || (state == FL_EMIT && out_fire && !out_last)) begin
      out_llr         <= msg_llr;
      out_last        <= (src_edge == idx_t'(`CNODE_DEG-1));
      out_parity_fail <= src_parity;  // odd count of negatives
    end
  end

endmodule

`default_nettype wire

/* hw/cnode_macros.svh */
// ---------------------------------------
// check node sizing and normalization macros
// ---------------------------------------

`ifndef CNODE_MACROS_SVH
`define CNODE_MACROS_SVH

// signed LLR width, sign bit included
`define CNODE_LLR_W 5

// beats per row, one LLR per beat
`define CNODE_DEG 8

// normalization factor in eighths, 6 gives 0.75
`define CNODE_NORM 6

// row records held between sorter and flush engine
`define CNODE_FIFO_DEPTH 2

`endif

/* hw/cnode_pkg.sv */
// ---------------------------------------
// check node types and flush state enum
// ---------------------------------------

`default_nettype none

`include "cnode_macros.svh"

package cnode_pkg;

  // message types
  typedef logic signed [`CNODE_LLR_W-1:0] llr_t;    // signed LLR
  typedef logic        [`CNODE_LLR_W-2:0] mag_t;    // saturated magnitude

  // row bookkeeping
  typedef logic [$clog2(`CNODE_DEG)-1:0] idx_t;     // edge position in a row
  typedef logic [`CNODE_DEG-1:0]         sign_vec_t; // bit i is edge i sign

  // flush engine FSM
  typedef enum logic {
    FL_IDLE,  // waiting for a record
    FL_EMIT   // sending the row back out
  } flush_state_t;

endpackage

`default_nettype wire

/* hw/cnode_proc.sv */
// ---------------------------------------
// check node processor top level
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cnode_macros.svh"

module cnode_proc (
  input  logic            iclk,
  input  logic            ireset,
  // variable to check messages
  input  logic            in_valid,
  input  cnode_pkg::llr_t in_llr,
  output logic            in_ready,
  // check to variable messages
  output logic            out_valid,
  input  logic            out_ready,
  output cnode_pkg::llr_t out_llr,
  output logic            out_last,
  output logic            out_parity_fail
);

  import cnode_pkg::*;

  //---------------------------------------
  // sorter to FIFO
  //---------------------------------------
  logic      push_valid, push_ready;
  mag_t      rec_min1, rec_min2;
  idx_t      rec_min1_idx;
  sign_vec_t rec_signs;
  logic      rec_parity;

  //---------------------------------------
  // FIFO to flush engine
  //---------------------------------------
  logic      pop_valid, pop_ready;
  mag_t      pop_min1, pop_min2;
  idx_t      pop_min1_idx;
  sign_vec_t pop_signs;
  logic      pop_parity;

  cnode_sorter sorter_i (
    .iclk         (iclk),
    .ireset       (ireset),
    .in_valid     (in_valid),
    .in_llr       (in_llr),
    .in_ready     (in_ready),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .rec_min1     (rec_min1),
    .rec_min2     (rec_min2),
    .rec_min1_idx (rec_min1_idx),
    .rec_signs    (rec_signs),
    .rec_parity   (rec_parity)
  );

  cnode_row_fifo #(
    .DEPTH (`CNODE_FIFO_DEPTH)  // lets the sorter run one row ahead
  ) fifo_i (
    .iclk         (iclk),
    .ireset       (ireset),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .rec_min1     (rec_min1),
    .rec_min2     (rec_min2),
    .rec_min1_idx (rec_min1_idx),
    .rec_signs    (rec_signs),
    .rec_parity   (rec_parity),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_min1     (pop_min1),
    .pop_min2     (pop_min2),
    .pop_min1_idx (pop_min1_idx),
    .pop_signs    (pop_signs),
    .pop_parity   (pop_parity)
  );

  cnode_flush flush_i (
    .iclk            (iclk),
    .ireset          (ireset),
    .pop_valid       (pop_valid),
    .pop_ready       (pop_ready),
    .pop_min1        (pop_min1),
    .pop_min2        (pop_min2),
    .pop_min1_idx    (pop_min1_idx),
    .pop_signs       (pop_signs),
    .pop_parity      (pop_parity),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_llr         (out_llr),
    .out_last        (out_last),
    .out_parity_fail (out_parity_fail)
  );

endmodule

`default_nettype wire

/* hw/cnode_row_fifo.sv */
// ---------------------------------------
// valid/ready FIFO of row records
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cnode_macros.svh"

module cnode_row_fifo #(
  parameter int DEPTH = `CNODE_FIFO_DEPTH
) (
  input  logic                 iclk,
  input  logic                 ireset,
  // write side
  input  logic                 push_valid,
  output logic                 push_ready,
  input  cnode_pkg::mag_t      rec_min1,
  input  cnode_pkg::mag_t      rec_min2,
  input  cnode_pkg::idx_t      rec_min1_idx,
  input  cnode_pkg::sign_vec_t rec_signs,
  input  logic                 rec_parity,
  // read side
  output logic                 pop_valid,
  input  logic                 pop_ready,
  output cnode_pkg::mag_t      pop_min1,
  output cnode_pkg::mag_t      pop_min2,
  output cnode_pkg::idx_t      pop_min1_idx,
  output cnode_pkg::sign_vec_t pop_signs,
  output logic                 pop_parity
);

  import cnode_pkg::*;

  localparam int REC_W = 2 * $bits(mag_t) + $bits(idx_t) + $bits(sign_vec_t) + 1;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [REC_W-1:0] mem [DEPTH];  // packed records
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;        // records held
  logic             push_fire, pop_fire;

  assign push_ready = (count != CNT_W'(DEPTH));  // low only when full
  assign pop_valid  = (count != '0);
  assign push_fire  = push_valid & push_ready;
  assign pop_fire   = pop_valid & pop_ready;

  // head record straight from storage
  assign {pop_min1, pop_min2, pop_min1_idx, pop_signs, pop_parity} = mem[rd_ptr];

  //---------------------------------------
  // pointers and occupancy
  //---------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_fire)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      if (push_fire && !pop_fire)
        count <= count + 1'b1;
      else if (pop_fire && !push_fire)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge iclk) begin
    if (push_fire)
      mem[wr_ptr] <= {rec_min1, rec_min2, rec_min1_idx, rec_signs, rec_parity};
  end

endmodule

`default_nettype wire

/* hw/cnode_sorter.sv */
// ---------------------------------------
// sequential two-minimum sort, one record per row
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cnode_macros.svh"

module cnode_sorter (
  input  logic                 iclk,
  input  logic                 ireset,
  // input stream
  input  logic                 in_valid,
  input  cnode_pkg::llr_t      in_llr,
  output logic                 in_ready,
  // record towards the FIFO
  output logic                 push_valid,
  input  logic                 push_ready,
  output cnode_pkg::mag_t      rec_min1,
  output cnode_pkg::mag_t      rec_min2,
  output cnode_pkg::idx_t      rec_min1_idx,
  output cnode_pkg::sign_vec_t rec_signs,
  output logic                 rec_parity
);

  import cnode_pkg::*;

  localparam mag_t MAG_MAX = '1;  // also the min2 seed on a new row

  logic      in_fire;
  logic      first_beat, last_beat;
  idx_t      beat_cnt;          // edge position of the current beat
  mag_t      in_mag;
  logic      in_sign;

  // running state of the row in progress
  mag_t      run_min1, run_min2;
  idx_t      run_idx;
  sign_vec_t run_signs;
  logic      run_parity;

  // running state plus the current beat
  mag_t      base_min1, base_min2, nxt_min1, nxt_min2;
  idx_t      base_idx, nxt_idx;
  sign_vec_t base_signs, nxt_signs;
  logic      base_parity, nxt_parity;
  logic      check1, check3;

  // abs value, saturated for the most negative code
  function automatic mag_t llr_mag(input llr_t v);
    llr_t neg;
    neg = -v;
    if (!v[`CNODE_LLR_W-1])
      return v[`CNODE_LLR_W-2:0];
    else if (neg[`CNODE_LLR_W-1])
      return MAG_MAX;             // -2^(W-1) has no positive twin
    else
      return neg[`CNODE_LLR_W-2:0];
  endfunction

  assign in_ready   = ~push_valid;  // stall only while a record waits
  assign in_fire    = in_valid & in_ready;
  assign first_beat = (beat_cnt == '0);
  assign last_beat  = (beat_cnt == idx_t'(`CNODE_DEG-1));
  assign in_mag     = llr_mag(in_llr);
  assign in_sign    = in_llr[`CNODE_LLR_W-1];

  //---------------------------------------
  // insertion of the new beat
  //---------------------------------------

  always_comb begin
    // first beat starts from an empty row
    base_min1   = first_beat ? MAG_MAX : run_min1;
    base_min2   = first_beat ? MAG_MAX : run_min2;
    base_idx    = first_beat ? '0      : run_idx;
    base_signs  = first_beat ? '0      : run_signs;
    base_parity = first_beat ? 1'b0    : run_parity;

    check1 = (in_mag < base_min1);  // strict, earlier index wins a tie
    check3 = (in_mag < base_min2);  // a tie on min1 still lands in min2

    nxt_min1 = check1 ? in_mag   : base_min1;
    nxt_min2 = check1 ? base_min1 : (check3 ? in_mag : base_min2);
    nxt_idx  = check1 ? beat_cnt : base_idx;

    nxt_signs           = base_signs;
    nxt_signs[beat_cnt] = in_sign;
    nxt_parity          = base_parity ^ in_sign;
  end

  //---------------------------------------
  // control
  //---------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beat_cnt   <= '0;
      push_valid <= 1'b0;
    end else begin
      if (in_fire)
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      // record leaves when the FIFO takes it
      if (in_fire && last_beat)
        push_valid <= 1'b1;
      else if (push_ready)
        push_valid <= 1'b0;
    end
  end

  // payload, running row and finished record
  always_ff @(posedge iclk) begin
    if (in_fire) begin
      run_min1   <= nxt_min1;
      run_min2   <= nxt_min2;
      run_idx    <= nxt_idx;
      run_signs  <= nxt_signs;
      run_parity <= nxt_parity;
    end
    if (in_fire && last_beat) begin  // frees the running regs for the next row
      rec_min1     <= nxt_min1;
      rec_min2     <= nxt_min2;
      rec_min1_idx <= nxt_idx;
      rec_signs    <= nxt_signs;
      rec_parity   <= nxt_parity;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the check node processor testbench with Verilator
# exit status is nonzero when the testbench reports failure

set -e

cd "$(dirname "$0")"

TOP=cnode_proc_tb
OBJ=obj_dir

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module "${TOP}" \
  -f cnode_proc.f \
  -Mdir "${OBJ}" \
  -o "${TOP}_sim"

"./${OBJ}/${TOP}_sim"

/* test/cnode_proc_props.sv */
// ---------------------------------------
// output stream assertions, bound to the top level
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cnode_macros.svh"

module cnode_proc_props (
  input logic            iclk,
  input logic            ireset,
  input logic            out_valid,
  input logic            out_ready,
  input cnode_pkg::llr_t out_llr,
  input logic            out_last,
  input logic            out_parity_fail
);

  import cnode_pkg::*;

  localparam int CNT_W = $clog2(`CNODE_DEG);

  logic [CNT_W-1:0] hs_cnt;  // handshakes within the current row

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)
      hs_cnt <= '0;
    else if (out_valid && out_ready)
      hs_cnt <= (hs_cnt == CNT_W'(`CNODE_DEG - 1)) ? '0 : hs_cnt + 1'b1;
  end

  // stalled output holds its payload
  a_out_hold: assert property (@(posedge iclk) disable iff (ireset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_llr) && $stable(out_last)
                                   && $stable(out_parity_fail)))
    else $error("output changed while stalled");

  a_no_valid_in_reset: assert property (@(posedge iclk) ireset |-> !out_valid)
    else $error("out_valid high during reset");

  // last flag on every CNODE_DEG-th handshake only
  a_last_spacing: assert property (@(posedge iclk) disable iff (ireset)
    (out_valid && out_ready) |-> (out_last == (hs_cnt == CNT_W'(`CNODE_DEG - 1))))
    else $error("out_last out of place");

endmodule

bind cnode_proc cnode_proc_props props_i (
  .iclk            (iclk),
  .ireset          (ireset),
  .out_valid       (out_valid),
  .out_ready       (out_ready),
  .out_llr         (out_llr),
  .out_last        (out_last),
  .out_parity_fail (out_parity_fail)
);

`default_nettype wire

/* test/cnode_proc_tb.sv */
// ---------------------------------------
// testbench for the check node processor
// reference model, monitor, directed and random row tests, watchdog
// ---------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "cnode_macros.svh"

module cnode_proc_tb;

  import cnode_pkg::*;

  localparam int          DEG        = `CNODE_DEG;
  localparam int          MAXMAG     = (1 << (`CNODE_LLR_W - 1)) - 1;  // saturation point
  localparam logic [31:0] SEED       = 32'hd65;
  localparam int          TOTAL_ROWS = 1 + 2 + 2 + 20 + 20;
  // four times the unstalled row time plus reset and slack
  localparam int          WATCHDOG_CYCLES = 10 + TOTAL_ROWS * (DEG + 1) * 4 + 200;

  typedef logic [DEG-1:0][`CNODE_LLR_W-1:0] row_t;  // slice i is edge i

  logic        iclk = 1'b0;
  logic        ireset;
  logic        in_valid;
  llr_t        in_llr;
  logic        in_ready;
  logic        out_valid;
  logic        out_ready;
  llr_t        out_llr;
  logic        out_last;
  logic        out_parity_fail;

  logic [31:0] rng       = SEED;  // row data, main process only
  logic [31:0] ready_rng = SEED;  // out_ready pattern
  bit          stall_mode = 1'b0;
  int          low_run = 0;          // cycles in a row with in_valid high and in_ready low
  int          longest_low_run = 0;  // longest such run since the last clear

  // expected messages, in output order
  int          exp_llr [$];
  int          exp_last [$];
  int          exp_pf [$];

  always #20 iclk = ~iclk;  // 40 ns period

  cnode_proc dut_i (
    .iclk            (iclk),
    .ireset          (ireset),
    .in_valid        (in_valid),
    .in_llr          (in_llr),
    .in_ready        (in_ready),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_llr         (out_llr),
    .out_last        (out_last),
    .out_parity_fail (out_parity_fail)
  );

  //----------------------------------------
  // reporting
  //----------------------------------------

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    if (got != exp)
      fail_run($sformatf("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  //----------------------------------------
  // stimulus helpers and reference model
  //----------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic row_t make_row(input int e0, e1, e2, e3, e4, e5, e6, e7);
    int   v [DEG];
    row_t r;
    v = '{e0, e1, e2, e3, e4, e5, e6, e7};
    for (int i = 0; i < DEG; i++)
      r[i] = v[i][`CNODE_LLR_W-1:0];  // two's complement slice
    return r;
  endfunction

  function automatic row_t random_row();
    row_t r;
    for (int i = 0; i < DEG; i++) begin
      rng  = xorshift32(rng);
      r[i] = rng[`CNODE_LLR_W-1:0];  // covers the whole signed range including -16
    end
    return r;
  endfunction

  function automatic int mag_of(input llr_t v);
    int x;
    x = int'(v);
    if (x < 0)
      x = -x;
    if (x > MAXMAG)
      x = MAXMAG;   // -16 clips to 15
    return x;
  endfunction

  function automatic int norm_of(input int m);
    return (m * `CNODE_NORM + 4) >> 3;  // times NORM eighths with rounding
  endfunction

  // expected messages of one row in edge order
  function automatic void expect_row(input row_t row);
    int   mags [DEG];
    int   negs [DEG];
    int   par, m, s, val;
    llr_t v;
    par = 0;
    for (int j = 0; j < DEG; j++) begin
      v       = row[j];
      mags[j] = mag_of(v);
      negs[j] = (v < 0) ? 1 : 0;
      par     = par ^ negs[j];
    end
    for (int i = 0; i < DEG; i++) begin
      m = MAXMAG;
      s = 0;
      for (int j = 0; j < DEG; j++) begin
        if (j != i) begin  // every other edge of the row
          if (mags[j] < m)
            m = mags[j];
          s = s ^ negs[j];
        end
      end
      val = norm_of(m);
      if (s != 0)
        val = -val;
      exp_llr.push_back(val);
      exp_last.push_back((i == DEG - 1) ? 1 : 0);
      exp_pf.push_back(par);
    end
  endfunction

  //----------------------------------------
  // driver tasks enter and leave 2 ns after a rising edge
  //----------------------------------------

  task automatic send_row(input row_t row);
    bit accepted;
    expect_row(row);
    for (int i = 0; i < DEG; i++) begin
      in_valid = 1'b1;
      in_llr   = row[i];
      do begin
        @(negedge iclk);
        accepted = in_ready;  // stable until the next edge
        @(posedge iclk);
        #2;
      end while (!accepted);
    end
  endtask

  task automatic stop_input();
    in_valid = 1'b0;
    in_llr   = '0;
  endtask

  task automatic wait_drained();
    while (exp_llr.size() != 0) begin
      @(posedge iclk);
      #2;
    end
  endtask

  // switched mid cycle away from the out_ready update
  task automatic set_stall(input bit on);
    @(negedge iclk);
    stall_mode = on;
    @(posedge iclk);
    #2;
  endtask

  //----------------------------------------
  // tests
  //----------------------------------------

  task automatic run_directed_row();
    send_row(make_row(11, -9, 13, -4, 15, -12, 10, 14));  // distinct magnitudes
    stop_input();
    wait_drained();
  endtask

  task automatic run_tie_and_saturation();
    send_row(make_row(6, -3, 9, 3, -12, 7, 3, 10));       // minimum 3 on three edges
    send_row(make_row(-16, -16, 13, 14, -15, 15, 12, -16));
    stop_input();
    wait_drained();
  endtask

  task automatic run_parity_rows();
    send_row(make_row(5, 6, -7, 8, 9, 10, 11, 12));       // one negative
    send_row(make_row(-5, 6, -7, 8, 9, 10, 11, 12));      // two negatives
    stop_input();
    wait_drained();
  endtask

  task automatic run_random_rows(input int nrows, input bit stall);
    row_t rows [$];
    for (int r = 0; r < nrows; r++)
      rows.push_back(random_row());  // drawn before the ready pattern starts
    // one idle cycle per row boundary is normal, a full FIFO holds it longer
    longest_low_run = 0;
    if (stall)
      set_stall(1'b1);
    foreach (rows[r])
      send_row(rows[r]);
    stop_input();
    wait_drained();
    if (stall) begin
      set_stall(1'b0);
      check_value((longest_low_run > 1) ? 1 : 0, 1, "in_ready held low under back-pressure");
    end
  endtask

  //----------------------------------------
  // processes
  //----------------------------------------

  initial begin : main
    in_valid = 1'b0;
    in_llr   = '0;
    ireset   = 1'b1;
    repeat (10) @(posedge iclk);
    #2;
    ireset = 1'b0;
    check_value(int'(in_ready), 1, "in_ready after reset");
    check_value(int'(out_valid), 0, "out_valid after reset");
    run_directed_row();
    run_tie_and_saturation();
    run_parity_rows();
    run_random_rows(20, 1'b0);
    run_random_rows(20, 1'b1);
    $display("NO ERRORS");
    $finish;
  end

  // out_ready always high or random with long low stretches
  initial begin : ready_gen
    int hold;
    hold      = 0;
    out_ready = 1'b1;
    forever begin
      @(posedge iclk);
      #2;
      if (!stall_mode) begin
        out_ready = 1'b1;
        hold      = 0;
      end else if (hold > 0) begin
        hold--;
      end else begin
        ready_rng = xorshift32(ready_rng);
        out_ready = ~out_ready;
        hold      = out_ready ? int'(ready_rng[2:0]) : 1 + int'(ready_rng[4:1]);
      end
    end
  end

  // handshake sampled at the falling edge before the rising edge that completes it
  always @(negedge iclk) begin : monitor
    int e_llr, e_last, e_pf;
    if (!ireset) begin
      if (in_valid && !in_ready) begin
        low_run++;
        if (low_run > longest_low_run)
          longest_low_run = low_run;
      end else begin
        low_run = 0;
      end
      if (out_valid && out_ready) begin
        if (exp_llr.size() == 0) begin
          fail_run("an output message arrived with none left to expect");
        end else begin
          e_llr  = exp_llr.pop_front();
          e_last = exp_last.pop_front();
          e_pf   = exp_pf.pop_front();
          check_value(int'(out_llr), e_llr, "out_llr");
          check_value(int'(out_last), e_last, "out_last");
          check_value(int'(out_parity_fail), e_pf, "out_parity_fail");
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge iclk);
    fail_run("timeout: outputs stopped arriving");
  end

endmodule

`default_nettype wire
